/* bench/fetch_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_assert #(
    parameter int unsigned FETCH_WIDTH   = 2,
    parameter int unsigned REFILL_CYCLES = 3
) (
    input logic                                       clock,
    input logic                                       reset,
    input logic                                       flush_i,
    input logic                                       fetch_enable_i,
    input fetch_pkg::if_id_packet_t [FETCH_WIDTH-1:0] packets_i
);
    import fetch_pkg::*;

    logic [FETCH_WIDTH-1:0]   lane_valid;
    logic [REFILL_CYCLES-1:0] flush_hist;

    for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_valid
        assign lane_valid[k] = packets_i[k].valid;
    end

    // Recent flushes, newest in bit 0
    always_ff @(posedge clock) begin
        if (reset) begin
            flush_hist <= '0;
        end else begin
            flush_hist <= {flush_hist[REFILL_CYCLES-2:0], flush_i};
        end
    end

    a_dark_on_reset_flush: assert property (@(posedge clock)
        (reset || flush_i) |-> (lane_valid == '0))
        else $error("valid lane during reset or flush");

    for (genvar k = 0; k + 1 < FETCH_WIDTH; k++) begin : g_lane_pair
        a_valid_prefix: assert property (@(posedge clock) disable iff (reset)
            lane_valid[k+1] |-> lane_valid[k])
            else $error("lane %0d valid without lane %0d", k + 1, k);

        a_pc_step: assert property (@(posedge clock) disable iff (reset)
            lane_valid[0] |-> (packets_i[k+1].pc == packets_i[k].pc + 32'd4))
            else $error("lane %0d PC not consecutive", k + 1);
    end

    a_refill_hold: assert property (@(posedge clock) disable iff (reset)
        (|flush_hist) |-> !fetch_enable_i)
        else $error("fetch enabled during refill");

endmodule

bind fetch_stage fetch_assert #(
    .FETCH_WIDTH (FETCH_WIDTH)
) u_fetch_assert (
    .clock          (clock),
    .reset          (reset),
    .flush_i        (flush_i),
    .fetch_enable_i (fetch_enable_i),
    .packets_i      (packets_o)
);

`default_nettype wire

/* bench/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int FETCH_WIDTH     = 2;
    localparam int BTB_ENTRIES     = 16;
    localparam int MEM_WORDS       = 256;
    localparam int REFILL_CYCLES   = 3;
    localparam int RANDOM_CYCLES   = 240;
    localparam int DIRECTED_CYCLES = 100;
    // Load, reset, directed and random cycles plus some slack
    localparam int LIMIT_CYCLES    = MEM_WORDS + 4 + DIRECTED_CYCLES + RANDOM_CYCLES + 100;
    localparam inst_t MARKER       = 32'hC0DE_0000;

    // Model BTB entry keeps the whole branch PC
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t target;
    } btb_entry_t;

    typedef if_id_packet_t [FETCH_WIDTH-1:0] lanes_t;

    logic            clock;
    logic            reset;
    logic            stall;
    logic            resolve_valid;
    branch_resolve_t resolve;
    logic            load_valid;
    addr_t           load_addr;
    inst_t           load_data;
    lanes_t          packets;

    // Reference model state
    inst_t                        model_mem [MEM_WORDS];
    addr_t                        model_pc;
    btb_entry_t [BTB_ENTRIES-1:0] model_btb;
    fetch_state_t                 model_state;
    int                           refill_left;
    logic                         reset_seen;
    logic [15:0]                  lfsr_state;
    int                           errors;
    int                           checks;
    int                           tests_run;
    int                           test_errors;
    string                        test_name;

    fetch_top #(
        .FETCH_WIDTH   (FETCH_WIDTH),
        .BTB_ENTRIES   (BTB_ENTRIES),
        .MEM_WORDS     (MEM_WORDS),
        .REFILL_CYCLES (REFILL_CYCLES)
    ) dut0 (
        .clock           (clock),
        .reset           (reset),
        .stall_i         (stall),
        .resolve_valid_i (resolve_valid),
        .resolve_i       (resolve),
        .load_valid_i    (load_valid),
        .load_addr_i     (load_addr),
        .load_data_i     (load_data),
        .packets_o       (packets)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ----------------------------------------
    // Random bits and reference model
    // ----------------------------------------

    // Taps 16, 14, 13, 11
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_field(input int bits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < bits; i++) begin
            v = {v[30:0], next_lfsr_bit()};
        end
        return v;
    endfunction

    function automatic void predict_packets(
        input  addr_t                        pc,
        input  btb_entry_t [BTB_ENTRIES-1:0] btb,
        input  fetch_state_t                 st,
        input  int                           left,
        input  logic                         stall_in,
        input  logic                         strobe,
        input  branch_resolve_t              rs,
        output lanes_t                       want_lanes,
        output addr_t                        next_pc
    );
        logic  flush;
        logic  enable;
        logic  hit;
        int    hit_lane;
        addr_t hit_target;
        addr_t lane_pc;
        int    idx;
        flush      = strobe && rs.mispredict;
        enable     = (st == RUN) && (left == 0) && !stall_in && !flush;
        hit        = 1'b0;
        hit_lane   = 0;
        hit_target = '0;
        // Lowest lane with a matching entry wins
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            lane_pc = pc + addr_t'(4 * k);
            idx     = int'((lane_pc >> 2) % BTB_ENTRIES);
            if (!hit && btb[idx].valid && btb[idx].pc[31:2] == lane_pc[31:2]) begin
                hit        = 1'b1;
                hit_lane   = k;
                hit_target = btb[idx].target;
            end
        end
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            lane_pc                 = pc + addr_t'(4 * k);
            want_lanes[k].valid     = enable && (!hit || k <= hit_lane);
            want_lanes[k].pc        = lane_pc;
            want_lanes[k].npc       = lane_pc + 32'd4;
            // Lane k reads word PC/4 plus k, memory wraps
            want_lanes[k].inst      = want_lanes[k].valid
                                      ? model_mem[int'((lane_pc >> 2) % MEM_WORDS)] : NOP_INST;
        end
        if (flush) next_pc = rs.target;
        else if (!enable) next_pc = pc;
        else if (hit) next_pc = hit_target;
        else next_pc = pc + addr_t'(4 * FETCH_WIDTH);
    endfunction

    // ----------------------------------------
    // Comparing process
    // ----------------------------------------
    task automatic report_mismatch(input string sig, input int lane,
                                   input logic [31:0] want_v, input logic [31:0] got_v);
        $display("MISMATCH time=%0t packets_o[%0d].%s expected %h actual %h",
                 $time, lane, sig, want_v, got_v);
        errors++;
    endtask

    task automatic compare_and_advance();
        lanes_t want;
        addr_t  next_pc;
        int     idx;
        predict_packets(model_pc, model_btb, model_state, refill_left,
                        stall, resolve_valid, resolve, want, next_pc);
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            checks++;
            if (packets[k].valid !== want[k].valid)
                report_mismatch("valid", k, 32'(want[k].valid), 32'(packets[k].valid));
            if (packets[k].pc !== want[k].pc)
                report_mismatch("pc", k, want[k].pc, packets[k].pc);
            if (packets[k].npc !== want[k].npc)
                report_mismatch("npc", k, want[k].npc, packets[k].npc);
            if (packets[k].inst !== want[k].inst)
                report_mismatch("inst", k, want[k].inst, packets[k].inst);
        end
        model_pc = next_pc;
        // BTB write lands after this cycle's lookup
        if (resolve_valid) begin
            idx = int'((resolve.pc >> 2) % BTB_ENTRIES);
            if (resolve.taken) begin
                model_btb[idx] = '{valid: 1'b1, pc: resolve.pc, target: resolve.target};
            end else if (model_btb[idx].valid && model_btb[idx].pc[31:2] == resolve.pc[31:2]) begin
                model_btb[idx].valid = 1'b0;
            end
        end
        if (resolve_valid && resolve.mispredict) begin
            model_state = REFILL;
            refill_left = REFILL_CYCLES;
        end else if (model_state == REFILL) begin
            refill_left--;
            if (refill_left == 0) model_state = RUN;
        end
    endtask

    // Sample in mid cycle, well away from both edges
    always @(negedge clock) begin
        if (reset) begin
            reset_seen = 1'b1;
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                if (packets[k].valid !== 1'b0)
                    report_mismatch("valid", k, 32'd0, 32'(packets[k].valid));
            end
            model_pc    = '0;
            model_btb   = '0;
            model_state = RUN;
            refill_left = 0;
        end else if (reset_seen) begin
            compare_and_advance();
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic next_slot();
        @(posedge clock);
        #10;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_slot();
    endtask

    task automatic load_program();
        for (int a = 0; a < MEM_WORDS; a++) begin
            load_valid   = 1'b1;
            load_addr    = addr_t'(4 * a);
            load_data    = MARKER + inst_t'(4 * a);
            model_mem[a] = MARKER + inst_t'(4 * a);
            next_slot();
        end
        load_valid = 1'b0;
    endtask

    // One-cycle strobe from execute
    task automatic send_resolve(input addr_t pc, input addr_t target,
                                input logic taken, input logic mispredict);
        resolve_valid = 1'b1;
        resolve       = '{pc: pc, target: target, taken: taken, mispredict: mispredict};
        next_slot();
        resolve_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %-12s %s, %0d mismatches", test_name,
                 (errors == test_errors) ? "ok" : "bad", errors - test_errors);
    endtask

    initial begin
        reset         = 1'b0;
        stall         = 1'b1;
        resolve_valid = 1'b0;
        resolve       = '0;
        load_valid    = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        reset_seen    = 1'b0;
        lfsr_state    = 16'd76;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        next_slot();
        // Stall keeps the lanes dark while memory fills
        load_program();
        reset = 1'b1;
        idle_cycles(3);
        reset = 1'b0;
        stall = 1'b0;

        start_test("sequential");
        idle_cycles(8);
        end_test();

        // Hit in lane 0, then a target at 4 mod 8
        start_test("predicted");
        send_resolve(32'h80, 32'h1C4, 1'b1, 1'b0);
        send_resolve(32'h1D4, 32'h300, 1'b1, 1'b0);
        idle_cycles(20);
        end_test();

        // Second flush lands inside refill
        start_test("flush");
        send_resolve(32'h310, 32'h40, 1'b0, 1'b1);
        idle_cycles(1);
        send_resolve(32'h204, 32'h100, 1'b1, 1'b1);
        idle_cycles(8);
        end_test();

        start_test("stall");
        stall = 1'b1;
        idle_cycles(4);
        stall = 1'b0;
        idle_cycles(6);
        end_test();

        // Clears the 0x80 entry and steers fetch back across it
        start_test("not_taken");
        send_resolve(32'h80, 32'h60, 1'b0, 1'b1);
        idle_cycles(12);
        end_test();

        start_test("random");
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            stall = (random_field(3) == 0);
            if (random_field(3) == 0) begin
                resolve_valid     = 1'b1;
                resolve.pc        = random_field(8) << 2;
                resolve.target    = random_field(8) << 2;
                resolve.taken     = next_lfsr_bit();
                resolve.mispredict = next_lfsr_bit();
            end else begin
                resolve_valid = 1'b0;
            end
            next_slot();
        end
        stall         = 1'b0;
        resolve_valid = 1'b0;
        idle_cycles(6);
        @(negedge clock);
        #1;
        end_test();

        $display("%0d tests, %0d lane checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_predictor #(
    parameter int unsigned FETCH_WIDTH = 2,
    parameter int unsigned BTB_ENTRIES = 16
) (
    input  logic                               clock,
    input  logic                               reset,
    input  fetch_pkg::addr_t [FETCH_WIDTH-1:0] lane_pc_i,
    input  logic                               resolve_valid_i,
    input  fetch_pkg::branch_resolve_t         resolve_i,
    output logic                               pred_valid_o,
    output logic [$clog2(FETCH_WIDTH)-1:0]     pred_lane_o,
    output fetch_pkg::addr_t                   pred_target_o
);
    import fetch_pkg::*;

    localparam int unsigned IDX_W  = $clog2(BTB_ENTRIES);
    localparam int unsigned TAG_W  = 32 - IDX_W - 2;
    localparam int unsigned LANE_W = $clog2(FETCH_WIDTH);

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;

    // Per-entry valid bit, tag and target
    logic [BTB_ENTRIES-1:0]       btb_valid;
    btb_tag_t                     btb_tag [BTB_ENTRIES];
    addr_t                        btb_target [BTB_ENTRIES];
    btb_idx_t [FETCH_WIDTH-1:0]   lane_idx;
    logic [FETCH_WIDTH-1:0]       lane_hit;
    btb_idx_t                     upd_idx;
    logic                         upd_match;

    // Index skips the two byte-offset bits
    function automatic btb_idx_t pc_index(input addr_t pc);
        return pc[IDX_W+1:2];
    endfunction

    function automatic btb_tag_t pc_tag(input addr_t pc);
        return pc[31:IDX_W+2];
    endfunction

    // ----------------------------------------
    // Lookup
    // ----------------------------------------
    for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_lookup
        assign lane_idx[k] = pc_index(lane_pc_i[k]);
        assign lane_hit[k] = btb_valid[lane_idx[k]]
                             && (btb_tag[lane_idx[k]] == pc_tag(lane_pc_i[k]));
    end

    // Walk down so the lowest hitting lane wins
    always_comb begin
        pred_valid_o  = 1'b0;
        pred_lane_o   = '0;
        pred_target_o = '0;
        for (int k = FETCH_WIDTH - 1; k >= 0; k--) begin
            if (lane_hit[k]) begin
                pred_valid_o  = 1'b1;
                pred_lane_o   = LANE_W'(k);
                pred_target_o = btb_target[lane_idx[k]];
            end
        end
    end

    // ----------------------------------------
    // Update from execute
    // ----------------------------------------
    assign upd_idx   = pc_index(resolve_i.pc);
    assign upd_match = btb_valid[upd_idx] && (btb_tag[upd_idx] == pc_tag(resolve_i.pc));

    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (resolve_valid_i) begin
            if (resolve_i.taken) begin
                btb_valid[upd_idx] <= 1'b1;
            end else if (upd_match) begin
                // Not taken kills only its own entry
                btb_valid[upd_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_valid_i && resolve_i.taken) begin
            btb_tag[upd_idx]    <= pc_tag(resolve_i.pc);
            btb_target[upd_idx] <= resolve_i.target;
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_control.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_control #(
    parameter int unsigned REFILL_CYCLES = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic stall_i,
    input  logic resolve_valid_i,
    input  logic resolve_mispredict_i,
    output logic flush_o,
    output logic fetch_enable_o
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    logic         timer_done;

    // Mispredict strobe flushes in its own cycle
    assign flush_o = resolve_valid_i && resolve_mispredict_i;

    // ----------------------------------------
    // Run / refill FSM
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (flush_o) state_next = REFILL;
            end
            REFILL: begin
                // A new flush keeps us here and restarts the wait
                if (!flush_o && timer_done) state_next = RUN;
            end
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    // Lanes stay dark while reset is held
    assign fetch_enable_o = !reset && (state == RUN) && !stall_i && !flush_o;

    refill_timer #(
        .CYCLES (REFILL_CYCLES)
    ) u_refill_timer (
        .clock   (clock),
        .reset   (reset),
        .start_i (flush_o),
        .done_o  (timer_done)
    );

endmodule

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // Byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    // One decode lane
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t npc;
        inst_t inst;
    } if_id_packet_t;

    // Execute verdict on one branch
    typedef struct packed {
        addr_t pc;
        addr_t target;
        logic  taken;
        logic  mispredict;
    } branch_resolve_t;

    // Fetch controller states
    typedef enum logic {
        RUN    = 1'b0,
        REFILL = 1'b1
    } fetch_state_t;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
    parameter int unsigned FETCH_WIDTH = 2
) (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       fetch_enable_i,
    input  logic                                       flush_i,
    input  fetch_pkg::addr_t                           redirect_pc_i,
    input  logic                                       pred_valid_i,
    input  logic [$clog2(FETCH_WIDTH)-1:0]             pred_lane_i,
    input  fetch_pkg::addr_t                           pred_target_i,
    input  mem_pkg::mem_block_t [FETCH_WIDTH-1:0]      imem_window_i,
    output mem_pkg::mem_addr_t                         imem_addr_o,
    output fetch_pkg::addr_t [FETCH_WIDTH-1:0]         lane_pc_o,
    output fetch_pkg::if_id_packet_t [FETCH_WIDTH-1:0] packets_o
);
    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int unsigned WIN_WORDS    = FETCH_WIDTH * BLOCK_WORDS;
    localparam addr_t       FETCH_STRIDE = addr_t'(4 * FETCH_WIDTH);

    addr_t                     pc_q;
    addr_t                     pc_d;
    mem_word_t [WIN_WORDS-1:0] window_words;
    logic [FETCH_WIDTH-1:0]    lane_valid;

    // ----------------------------------------
    // PC register
    // ----------------------------------------

    // Flush beats hold, hold beats prediction
    always_comb begin
        if (flush_i) begin
            pc_d = redirect_pc_i;
        end else if (!fetch_enable_i) begin
            pc_d = pc_q;
        end else if (pred_valid_i) begin
            pc_d = pred_target_i;
        end else begin
            pc_d = pc_q + FETCH_STRIDE;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_d;
        end
    end

    // Window starts at the PC rounded down to a block
    assign imem_addr_o = mem_addr_t'({pc_q[31:BLOCK_OFFSET], {BLOCK_OFFSET{1'b0}}});

    // ----------------------------------------
    // Lane packing
    // ----------------------------------------

    // Flatten the block window into consecutive words
    for (genvar b = 0; b < FETCH_WIDTH; b++) begin : g_flat
        for (genvar w = 0; w < BLOCK_WORDS; w++) begin : g_word
            assign window_words[b * BLOCK_WORDS + w] = imem_window_i[b].word[w];
        end
    end

    for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_lane
        addr_t lane_pc;
        inst_t lane_inst;

        assign lane_pc = pc_q + addr_t'(4 * k);

        // Odd-word PC shifts every lane up by one word
        assign lane_inst = window_words[k + int'(pc_q[2])];

        // Lanes past the predicted branch are dropped
        assign lane_valid[k] = fetch_enable_i && !flush_i
                               && (!pred_valid_i || (int'(pred_lane_i) >= k));

        assign lane_pc_o[k]         = lane_pc;
        assign packets_o[k].valid   = lane_valid[k];
        assign packets_o[k].pc      = lane_pc;
        assign packets_o[k].npc     = lane_pc + addr_t'(4);
        assign packets_o[k].inst    = lane_valid[k] ? lane_inst : NOP_INST;
    end

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter int unsigned FETCH_WIDTH   = 2,
    parameter int unsigned BTB_ENTRIES   = 16,
    parameter int unsigned MEM_WORDS     = 256,
    parameter int unsigned REFILL_CYCLES = 3
) (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       stall_i,
    input  logic                                       resolve_valid_i,
    input  fetch_pkg::branch_resolve_t                 resolve_i,
    input  logic                                       load_valid_i,
    input  fetch_pkg::addr_t                           load_addr_i,
    input  fetch_pkg::inst_t                           load_data_i,
    output fetch_pkg::if_id_packet_t [FETCH_WIDTH-1:0] packets_o
);
    import fetch_pkg::*;
    import mem_pkg::*;

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------
    logic                            flush;
    logic                            fetch_enable;
    mem_addr_t                       imem_addr;
    mem_block_t [FETCH_WIDTH-1:0]    imem_window;
    addr_t [FETCH_WIDTH-1:0]         lane_pc;
    logic                            pred_valid;
    logic [$clog2(FETCH_WIDTH)-1:0]  pred_lane;
    addr_t                           pred_target;

    fetch_control #(
        .REFILL_CYCLES (REFILL_CYCLES)
    ) u_fetch_control (
        .clock                (clock),
        .reset                (reset),
        .stall_i              (stall_i),
        .resolve_valid_i      (resolve_valid_i),
        .resolve_mispredict_i (resolve_i.mispredict),
        .flush_o              (flush),
        .fetch_enable_o       (fetch_enable)
    );

    // Redirect always goes to the resolved target
    fetch_stage #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) u_fetch_stage (
        .clock          (clock),
        .reset          (reset),
        .fetch_enable_i (fetch_enable),
        .flush_i        (flush),
        .redirect_pc_i  (resolve_i.target),
        .pred_valid_i   (pred_valid),
        .pred_lane_i    (pred_lane),
        .pred_target_i  (pred_target),
        .imem_window_i  (imem_window),
        .imem_addr_o    (imem_addr),
        .lane_pc_o      (lane_pc),
        .packets_o      (packets_o)
    );

    branch_predictor #(
        .FETCH_WIDTH (FETCH_WIDTH),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_branch_predictor (
        .clock           (clock),
        .reset           (reset),
        .lane_pc_i       (lane_pc),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i),
        .pred_valid_o    (pred_valid),
        .pred_lane_o     (pred_lane),
        .pred_target_o   (pred_target)
    );

    inst_mem #(
        .FETCH_WIDTH (FETCH_WIDTH),
        .MEM_WORDS   (MEM_WORDS)
    ) u_inst_mem (
        .clock        (clock),
        .load_valid_i (load_valid_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .addr_i       (imem_addr),
        .window_o     (imem_window)
    );

endmodule

`default_nettype wire

/* logic/inst_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_mem #(
    parameter int unsigned FETCH_WIDTH = 2,
    parameter int unsigned MEM_WORDS   = 256
) (
    input  logic                                  clock,
    input  logic                                  load_valid_i,
    input  fetch_pkg::addr_t                      load_addr_i,
    input  fetch_pkg::inst_t                      load_data_i,
    input  mem_pkg::mem_addr_t                    addr_i,
    output mem_pkg::mem_block_t [FETCH_WIDTH-1:0] window_o
);
    import mem_pkg::*;

    localparam int unsigned IDX_W = $clog2(MEM_WORDS);

    typedef logic [IDX_W-1:0] word_idx_t;

    mem_word_t mem [MEM_WORDS];
    word_idx_t load_idx;
    word_idx_t base_idx;

    // Upper address bits fall away, so addresses wrap
    assign load_idx = load_addr_i[WORD_OFFSET +: IDX_W];
    assign base_idx = addr_i[WORD_OFFSET +: IDX_W];

    // Word write from the load port
    always_ff @(posedge clock) begin
        if (load_valid_i) begin
            mem[load_idx] <= mem_word_t'(load_data_i);
        end
    end

    // Combinational window of consecutive blocks
    for (genvar b = 0; b < FETCH_WIDTH; b++) begin : g_block
        for (genvar w = 0; w < BLOCK_WORDS; w++) begin : g_word
            assign window_o[b].word[w] = mem[base_idx + word_idx_t'(b * BLOCK_WORDS + w)];
        end
    end

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Byte offset bits of a word and of a block
    localparam int unsigned WORD_OFFSET  = 2;
    localparam int unsigned BLOCK_OFFSET = 3;
    localparam int unsigned BLOCK_WORDS  = 2;

    typedef logic [31:0] mem_word_t;

    // Block aligned to 8 bytes
    typedef logic [31:0] mem_addr_t;

    // Word 0 sits at the lower address
    typedef struct packed {
        mem_word_t [BLOCK_WORDS-1:0] word;
    } mem_block_t;

endpackage

`default_nettype wire

/* logic/refill_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module refill_timer #(
    parameter int unsigned CYCLES = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic start_i,
    output logic done_o
);
    localparam int unsigned CNT_W = $clog2(CYCLES + 1);

    typedef logic [CNT_W-1:0] count_t;

    count_t count;

    // Restart wins over the running count
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (start_i) begin
            count <= count_t'(CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // High in the last refill cycle
    assign done_o = (count == count_t'(1));

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module fetch_tb \
    -Mdir obj_dir > "$LOG" 2>&1 \
    && ./obj_dir/Vfetch_tb >> "$LOG" 2>&1 \
    || echo "*** FAILED ***" >> "$LOG"

cat "$LOG"
grep -qF '*** FAILED ***' "$LOG" && exit 1 || exit 0

/* tb.f */
logic/fetch_pkg.sv
logic/mem_pkg.sv
logic/refill_timer.sv
logic/fetch_control.sv
logic/branch_predictor.sv
logic/inst_mem.sv
logic/fetch_stage.sv
logic/fetch_top.sv
bench/fetch_assert.sv
bench/fetch_tb.sv
